/* common/sw_pkg.sv */
// sw_pkg: sizes, scoring constants, score and index types, and controller states
package sw_pkg;

    // sizes
    localparam int REF_MAX_LENGTH  = 16;
    localparam int READ_MAX_LENGTH = 8;
    localparam int SCORE_WIDTH     = 10;

    localparam int REF_IDX_WIDTH  = $clog2(REF_MAX_LENGTH);
    localparam int READ_IDX_WIDTH = $clog2(READ_MAX_LENGTH);

    // wide enough for ref length plus the array depth
    localparam int CALC_CNT_WIDTH = $clog2(REF_MAX_LENGTH + READ_MAX_LENGTH) + 1;

    // 2-bit nucleotide code
    typedef logic [1:0] base_t;

    typedef logic signed [SCORE_WIDTH-1:0] score_t;

    typedef logic [REF_IDX_WIDTH-1:0]  ref_idx_t;
    typedef logic [READ_IDX_WIDTH-1:0] read_idx_t;

    // 1-based lengths
    typedef logic [REF_IDX_WIDTH:0]  ref_len_t;
    typedef logic [READ_IDX_WIDTH:0] read_len_t;

    typedef logic [CALC_CNT_WIDTH-1:0] calc_cnt_t;

    // scoring
    localparam score_t MATCH_SCORE    = 2;
    localparam score_t MISMATCH_SCORE = -1;
    localparam score_t GAP_OPEN       = -2;
    localparam score_t GAP_EXTEND     = -1;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CALC,
        SELECT,
        DONE
    } ctrl_state_t;

endpackage

/* common/sw_pe_link_if.sv */
// sw_pe_link_if: reference base and scores passed from one processing element to the next
`timescale 1ns/1ps

interface sw_pe_link_if;

    logic           a_valid;
    sw_pkg::base_t  a_base;
    // H and F of the cell above
    sw_pkg::score_t h;
    sw_pkg::score_t f;

    modport up (
        output a_valid,
        output a_base,
        output h,
        output f
    );

    modport down (
        input a_valid,
        input a_base,
        input h,
        input f
    );

endinterface

/* sw_array/sw_pe.sv */
// sw_pe: one systolic cell row, computes H, E and F per column and keeps the row best
`timescale 1ns/1ps

module sw_pe (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_clear,
    input  logic              i_row_enable,
    input  sw_pkg::base_t     i_read_base,
    sw_pe_link_if.down        up,
    sw_pe_link_if.up          dn,
    output sw_pkg::score_t    o_row_best,
    output sw_pkg::ref_idx_t  o_row_best_col
);

    logic             cell_en;
    sw_pkg::score_t   sub_score;
    sw_pkg::score_t   diag_sum;
    sw_pkg::score_t   e_open;
    sw_pkg::score_t   e_ext;
    sw_pkg::score_t   f_open;
    sw_pkg::score_t   f_ext;
    sw_pkg::score_t   e_new;
    sw_pkg::score_t   f_new;
    sw_pkg::score_t   h_new;
    // left neighbours are this row's previous column
    sw_pkg::score_t   h_left;
    sw_pkg::score_t   e_left;
    sw_pkg::score_t   h_diag;
    sw_pkg::ref_idx_t col_cnt;

    function automatic sw_pkg::score_t max2(sw_pkg::score_t a, sw_pkg::score_t b);
        return (a > b) ? a : b;
    endfunction

    assign cell_en = up.a_valid && i_row_enable;

    assign sub_score = (up.a_base == i_read_base) ? sw_pkg::MATCH_SCORE
                                                  : sw_pkg::MISMATCH_SCORE;
    assign diag_sum  = h_diag + sub_score;

    assign e_open = h_left + sw_pkg::GAP_OPEN;
    assign e_ext  = e_left + sw_pkg::GAP_EXTEND;
    assign f_open = up.h + sw_pkg::GAP_OPEN;
    assign f_ext  = up.f + sw_pkg::GAP_EXTEND;

    // all three clamped at zero
    assign e_new = max2(max2('0, e_open), e_ext);
    assign f_new = max2(max2('0, f_open), f_ext);
    assign h_new = max2(max2('0, diag_sum), max2(e_new, f_new));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dn.a_valid     <= 1'b0;
            col_cnt        <= '0;
            o_row_best     <= '0;
            o_row_best_col <= '0;
        end else begin
            dn.a_valid <= up.a_valid;
            if (i_clear) begin
                col_cnt        <= '0;
                o_row_best     <= '0;
                o_row_best_col <= '0;
            end else if (up.a_valid) begin
                col_cnt <= col_cnt + 1'b1;
                // strict compare keeps the first column on ties
                if (cell_en && h_new > o_row_best) begin
                    o_row_best     <= h_new;
                    o_row_best_col <= col_cnt;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        dn.a_base <= up.a_base;
        dn.h      <= cell_en ? h_new : '0;
        dn.f      <= cell_en ? f_new : '0;
        if (i_clear) begin
            h_left <= '0;
            e_left <= '0;
            h_diag <= '0;
        end else if (cell_en) begin
            h_left <= h_new;
            e_left <= e_new;
            // top H of this column is the diagonal of the next one
            h_diag <= up.h;
        end
    end

endmodule

/* sw_array/sw_pe_array.sv */
// sw_pe_array: chain of processing elements, one per read base, fed by the reference stream
`timescale 1ns/1ps

module sw_pe_array (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_clear,
    input  logic                                         i_ref_valid,
    input  sw_pkg::base_t                                i_ref_base,
    input  logic [2*sw_pkg::READ_MAX_LENGTH-1:0]         i_read_bases,
    input  sw_pkg::read_len_t                            i_read_length,
    output sw_pkg::score_t   [sw_pkg::READ_MAX_LENGTH-1:0] o_row_best,
    output sw_pkg::ref_idx_t [sw_pkg::READ_MAX_LENGTH-1:0] o_row_best_col
);

    sw_pe_link_if link [sw_pkg::READ_MAX_LENGTH+1] ();

    // top boundary row is all zero scores
    assign link[0].a_valid = i_ref_valid;
    assign link[0].a_base  = i_ref_base;
    assign link[0].h       = '0;
    assign link[0].f       = '0;

    for (genvar k = 0; k < sw_pkg::READ_MAX_LENGTH; k++) begin : g_pe
        logic          row_en;
        sw_pkg::base_t read_base;

        assign row_en    = (k < i_read_length);
        assign read_base = i_read_bases[2*sw_pkg::READ_MAX_LENGTH-1-2*k -: 2];

        sw_pe u_pe (
            .clk            (clk),
            .rst            (rst),
            .i_clear        (i_clear),
            .i_row_enable   (row_en),
            .i_read_base    (read_base),
            .up             (link[k]),
            .dn             (link[k+1]),
            .o_row_best     (o_row_best[k]),
            .o_row_best_col (o_row_best_col[k])
        );
    end

endmodule

/* src/sw_controller.sv */
// sw_controller: job FSM, reference base streaming and read latching for the PE array
`timescale 1ns/1ps

module sw_controller (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_valid,
    input  logic [2*sw_pkg::REF_MAX_LENGTH-1:0]    i_sequence_ref,
    input  logic [2*sw_pkg::READ_MAX_LENGTH-1:0]   i_sequence_read,
    input  sw_pkg::ref_len_t                       i_ref_length,
    input  sw_pkg::read_len_t                      i_read_length,
    input  logic                                   i_ready,
    input  logic                                   i_scan_done,
    output logic                                   o_ready,
    output logic                                   o_valid,
    output logic                                   o_clear,
    output logic                                   o_ref_valid,
    output sw_pkg::base_t                          o_ref_base,
    output logic [2*sw_pkg::READ_MAX_LENGTH-1:0]   o_read_bases,
    output sw_pkg::read_len_t                      o_read_length,
    output logic                                   o_scan_start
);

    sw_pkg::ctrl_state_t                    state;
    sw_pkg::calc_cnt_t                      calc_cnt;
    sw_pkg::ref_len_t                       ref_len_q;
    logic                                   calc_last;
    logic [2*sw_pkg::REF_MAX_LENGTH-1:0]    ref_shift;

    // first reference base sits in the top bits
    assign o_ref_base  = ref_shift[2*sw_pkg::REF_MAX_LENGTH-1 -: 2];
    assign o_ref_valid = (state == sw_pkg::CALC) &&
                         (calc_cnt < sw_pkg::calc_cnt_t'(ref_len_q));

    // drain time lets the last base reach the bottom row
    assign calc_last = (calc_cnt == sw_pkg::calc_cnt_t'(ref_len_q) +
                        sw_pkg::calc_cnt_t'(sw_pkg::READ_MAX_LENGTH - 1));

    assign o_ready = (state == sw_pkg::IDLE);
    assign o_valid = (state == sw_pkg::DONE);
    assign o_clear = (state == sw_pkg::LOAD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= sw_pkg::IDLE;
            calc_cnt      <= '0;
            ref_len_q     <= '0;
            o_read_length <= '0;
            o_scan_start  <= 1'b0;
        end else begin
            o_scan_start <= 1'b0;
            case (state)
                sw_pkg::IDLE: begin
                    if (i_valid) begin
                        ref_len_q     <= i_ref_length;
                        o_read_length <= i_read_length;
                        state         <= sw_pkg::LOAD;
                    end
                end
                sw_pkg::LOAD: begin
                    calc_cnt <= '0;
                    state    <= sw_pkg::CALC;
                end
                sw_pkg::CALC: begin
                    calc_cnt <= calc_cnt + 1'b1;
                    if (calc_last) begin
                        o_scan_start <= 1'b1;
                        state        <= sw_pkg::SELECT;
                    end
                end
                sw_pkg::SELECT: begin
                    if (i_scan_done) begin
                        state <= sw_pkg::DONE;
                    end
                end
                sw_pkg::DONE: begin
                    if (i_ready) begin
                        state <= sw_pkg::IDLE;
                    end
                end
                default: state <= sw_pkg::IDLE;
            endcase
        end
    end

    // sequences are sampled on acceptance
    always_ff @(posedge clk) begin
        if (state == sw_pkg::IDLE && i_valid) begin
            ref_shift    <= i_sequence_ref;
            o_read_bases <= i_sequence_read;
        end else if (state == sw_pkg::CALC) begin
            ref_shift <= ref_shift << 2;
        end
    end

endmodule

/* src/sw_best_select.sv */
// sw_best_select: scans the row bests one per cycle for the overall best score
`timescale 1ns/1ps

module sw_best_select (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_start,
    input  sw_pkg::read_len_t                            i_read_length,
    input  sw_pkg::score_t   [sw_pkg::READ_MAX_LENGTH-1:0] i_row_best,
    input  sw_pkg::ref_idx_t [sw_pkg::READ_MAX_LENGTH-1:0] i_row_best_col,
    output logic                                         o_done,
    output sw_pkg::score_t                               o_score,
    output sw_pkg::read_idx_t                            o_row,
    output sw_pkg::ref_idx_t                             o_column
);

    logic              busy;
    logic              last_row;
    sw_pkg::read_idx_t row_idx;
    sw_pkg::score_t    cand;

    assign cand     = i_row_best[row_idx];
    assign last_row = (sw_pkg::read_len_t'(row_idx) + 1'b1 >= i_read_length);
    assign o_done   = busy && last_row;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            row_idx  <= '0;
            o_score  <= '0;
            o_row    <= '0;
            o_column <= '0;
        end else if (i_start) begin
            busy     <= 1'b1;
            row_idx  <= '0;
            o_score  <= '0;
            o_row    <= '0;
            o_column <= '0;
        end else if (busy) begin
            // earlier row wins a tie
            if (cand > o_score) begin
                o_score  <= cand;
                o_row    <= row_idx;
                o_column <= i_row_best_col[row_idx];
            end
            row_idx <= row_idx + 1'b1;
            if (last_row) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* src/sw_core.sv */
// sw_core: Smith-Waterman affine-gap alignment core, read vs reference window
`timescale 1ns/1ps

module sw_core (
    input  logic                                   clk,
    input  logic                                   rst,

    output logic                                   o_ready,
    input  logic                                   i_valid,
    input  logic [2*sw_pkg::REF_MAX_LENGTH-1:0]    i_sequence_ref,
    input  logic [2*sw_pkg::READ_MAX_LENGTH-1:0]   i_sequence_read,
    input  sw_pkg::ref_len_t                       i_ref_length,
    input  sw_pkg::read_len_t                      i_read_length,

    input  logic                                   i_ready,
    output logic                                   o_valid,
    output sw_pkg::score_t                         o_alignment_score,
    output sw_pkg::ref_idx_t                       o_column,
    output sw_pkg::read_idx_t                      o_row
);

    logic                                   clear;
    logic                                   ref_valid;
    sw_pkg::base_t                          ref_base;
    logic [2*sw_pkg::READ_MAX_LENGTH-1:0]   read_bases;
    sw_pkg::read_len_t                      read_length;
    logic                                   scan_start;
    logic                                   scan_done;

    sw_pkg::score_t   [sw_pkg::READ_MAX_LENGTH-1:0] row_best;
    sw_pkg::ref_idx_t [sw_pkg::READ_MAX_LENGTH-1:0] row_best_col;

    sw_controller u_controller (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .i_sequence_ref  (i_sequence_ref),
        .i_sequence_read (i_sequence_read),
        .i_ref_length    (i_ref_length),
        .i_read_length   (i_read_length),
        .i_ready         (i_ready),
        .i_scan_done     (scan_done),
        .o_ready         (o_ready),
        .o_valid         (o_valid),
        .o_clear         (clear),
        .o_ref_valid     (ref_valid),
        .o_ref_base      (ref_base),
        .o_read_bases    (read_bases),
        .o_read_length   (read_length),
        .o_scan_start    (scan_start)
    );

    sw_pe_array u_array (
        .clk            (clk),
        .rst            (rst),
        .i_clear        (clear),
        .i_ref_valid    (ref_valid),
        .i_ref_base     (ref_base),
        .i_read_bases   (read_bases),
        .i_read_length  (read_length),
        .o_row_best     (row_best),
        .o_row_best_col (row_best_col)
    );

    sw_best_select u_select (
        .clk            (clk),
        .rst            (rst),
        .i_start        (scan_start),
        .i_read_length  (read_length),
        .i_row_best     (row_best),
        .i_row_best_col (row_best_col),
        .o_done         (scan_done),
        .o_score        (o_alignment_score),
        .o_row          (o_row),
        .o_column       (o_column)
    );

endmodule

/* tests/sw_core_assertions.sv */
// sw_core_assertions: concurrent checks on the core's result handshake
`timescale 1ns/1ps

module sw_core_assertions (
    input logic                clk,
    input logic                rst,
    input logic                i_core_ready,
    input logic                i_core_valid,
    input logic                i_sink_ready,
    input sw_pkg::score_t      i_score,
    input sw_pkg::read_idx_t   i_row,
    input sw_pkg::ref_idx_t    i_column
);

    int fail_count = 0;

    a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
        !(i_core_valid && i_core_ready))
        else begin
            $error("o_valid and o_ready high together");
            fail_count++;
        end

    // result held until the sink takes it
    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        i_core_valid && !i_sink_ready |=>
            i_core_valid && $stable(i_score) && $stable(i_row) && $stable(i_column))
        else begin
            $error("result changed or o_valid dropped before i_ready");
            fail_count++;
        end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> i_core_ready)
        else begin
            $error("o_ready low in the cycle after reset release");
            fail_count++;
        end

endmodule

bind sw_core sw_core_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .i_core_ready (o_ready),
    .i_core_valid (o_valid),
    .i_sink_ready (i_ready),
    .i_score      (o_alignment_score),
    .i_row        (o_row),
    .i_column     (o_column)
);

/* tests/tb_sw_core.sv */
// tb_sw_core: directed and random-job testbench for the Smith-Waterman core
`timescale 1ns/1ps

module tb_sw_core;

    logic                                   clk;
    logic                                   rst;
    logic                                   o_ready;
    logic                                   i_valid;
    logic [2*sw_pkg::REF_MAX_LENGTH-1:0]    i_sequence_ref;
    logic [2*sw_pkg::READ_MAX_LENGTH-1:0]   i_sequence_read;
    sw_pkg::ref_len_t                       i_ref_length;
    sw_pkg::read_len_t                      i_read_length;
    logic                                   i_ready;
    logic                                   o_valid;
    sw_pkg::score_t                         o_alignment_score;
    sw_pkg::ref_idx_t                       o_column;
    sw_pkg::read_idx_t                      o_row;

    sw_pkg::base_t ref_b  [sw_pkg::REF_MAX_LENGTH];
    sw_pkg::base_t read_b [sw_pkg::READ_MAX_LENGTH];

    logic [15:0] lfsr = 16'd62052;
    int err_count  = 0;
    int test_count = 0;
    int job_count  = 0;
    bit aborted    = 0;
    int last_score;
    int last_row;
    int last_col;

    sw_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    function automatic int max_int(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // reference model, scanned row by row so strict > keeps the earliest cell
    task automatic align_model(input int ref_len, input int read_len,
                               output int best, output int best_row, output int best_col);
        int h [0:sw_pkg::READ_MAX_LENGTH][0:sw_pkg::REF_MAX_LENGTH];
        int e [0:sw_pkg::READ_MAX_LENGTH][0:sw_pkg::REF_MAX_LENGTH];
        int f [0:sw_pkg::READ_MAX_LENGTH][0:sw_pkg::REF_MAX_LENGTH];
        int diag;
        h = '{default: 0};
        e = '{default: 0};
        f = '{default: 0};
        best     = 0;
        best_row = 0;
        best_col = 0;
        for (int i = 1; i <= read_len; i++) begin
            for (int j = 1; j <= ref_len; j++) begin
                e[i][j] = max_int(0, max_int(h[i][j-1] + int'(sw_pkg::GAP_OPEN),
                                             e[i][j-1] + int'(sw_pkg::GAP_EXTEND)));
                f[i][j] = max_int(0, max_int(h[i-1][j] + int'(sw_pkg::GAP_OPEN),
                                             f[i-1][j] + int'(sw_pkg::GAP_EXTEND)));
                diag = h[i-1][j-1] + ((read_b[i-1] == ref_b[j-1]) ?
                       int'(sw_pkg::MATCH_SCORE) : int'(sw_pkg::MISMATCH_SCORE));
                h[i][j] = max_int(max_int(0, diag), max_int(e[i][j], f[i][j]));
                if (h[i][j] > best) begin
                    best     = h[i][j];
                    best_row = i - 1;
                    best_col = j - 1;
                end
            end
        end
    endtask

    task automatic report_mismatch(input string sig, input int exp, input int got);
        $display("ERR %0t %s expected %0d got %0d", $time, sig, exp, got);
        err_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        err_count++;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!o_ready) begin
            n++;
            if (n > 100) begin
                report_failure("timeout, o_ready never came back high");
                aborted = 1;
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!o_valid) begin
            n++;
            if (n > 100) begin
                report_failure("timeout, o_valid never rose for the job");
                aborted = 1;
                return;
            end
            @(negedge clk);
        end
    endtask

    // offers ref_b/read_b as one job, checks the result, holds i_ready low for hold cycles
    task automatic run_job(input int ref_len, input int read_len, input int hold);
        int exp_score;
        int exp_row;
        int exp_col;
        logic [2*sw_pkg::REF_MAX_LENGTH-1:0]  seq_ref;
        logic [2*sw_pkg::READ_MAX_LENGTH-1:0] seq_read;
        if (aborted) return;
        align_model(ref_len, read_len, exp_score, exp_row, exp_col);
        for (int j = 0; j < sw_pkg::REF_MAX_LENGTH; j++) begin
            seq_ref[2*sw_pkg::REF_MAX_LENGTH-1-2*j -: 2] = ref_b[j];
        end
        for (int k = 0; k < sw_pkg::READ_MAX_LENGTH; k++) begin
            seq_read[2*sw_pkg::READ_MAX_LENGTH-1-2*k -: 2] = read_b[k];
        end
        wait_ready();
        if (aborted) return;
        @(posedge clk);
        i_valid         <= 1'b1;
        i_sequence_ref  <= seq_ref;
        i_sequence_read <= seq_read;
        i_ref_length    <= sw_pkg::ref_len_t'(ref_len);
        i_read_length   <= sw_pkg::read_len_t'(read_len);
        @(posedge clk);
        i_valid <= 1'b0;
        wait_valid();
        if (aborted) return;
        job_count++;
        last_score = int'(o_alignment_score);
        last_row   = int'(o_row);
        last_col   = int'(o_column);
        if (last_score != exp_score) report_mismatch("o_alignment_score", exp_score, last_score);
        if (last_row != exp_row) report_mismatch("o_row", exp_row, last_row);
        if (last_col != exp_col) report_mismatch("o_column", exp_col, last_col);
        for (int c = 0; c < hold; c++) begin
            @(negedge clk);
            if (!o_valid) report_failure("o_valid dropped while i_ready was low");
            if (o_ready) report_failure("o_ready rose before the hand-off");
            if (int'(o_alignment_score) != last_score) begin
                report_mismatch("o_alignment_score", last_score, int'(o_alignment_score));
            end
            if (int'(o_row) != last_row) report_mismatch("o_row", last_row, int'(o_row));
            if (int'(o_column) != last_col) report_mismatch("o_column", last_col, int'(o_column));
        end
        @(posedge clk);
        i_ready <= 1'b1;
        @(posedge clk);
        i_ready <= 1'b0;
        @(negedge clk);
        if (o_valid) report_failure("o_valid still high after the hand-off");
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, err_count - errs_before);
        end
    endtask

    task automatic fill_random();
        foreach (ref_b[j]) ref_b[j] = sw_pkg::base_t'(rand_bits(2));
        foreach (read_b[k]) read_b[k] = sw_pkg::base_t'(rand_bits(2));
    endtask

    task automatic test_exact_match();
        int errs_before;
        errs_before = err_count;
        ref_b  = '{0, 0, 0, 0, 0, 1, 2, 3, 3, 2, 1, 0, 0, 0, 0, 0};
        read_b = '{0, 1, 2, 3, 3, 2, 1, 0};
        run_job(16, 8, 0);
        if (last_score != 8 * int'(sw_pkg::MATCH_SCORE)) begin
            report_mismatch("o_alignment_score", 8 * int'(sw_pkg::MATCH_SCORE), last_score);
        end
        if (last_row != 7) report_mismatch("o_row", 7, last_row);
        if (last_col != 11) report_mismatch("o_column", 11, last_col);
        finish_test("exact_match", errs_before);
    endtask

    task automatic test_no_similarity();
        int errs_before;
        errs_before = err_count;
        foreach (ref_b[j]) ref_b[j] = sw_pkg::base_t'(rand_bits(1));
        foreach (read_b[k]) read_b[k] = 2'd3;
        run_job(16, 8, 0);
        if (last_score != 0) report_mismatch("o_alignment_score", 0, last_score);
        if (last_row != 0) report_mismatch("o_row", 0, last_row);
        if (last_col != 0) report_mismatch("o_column", 0, last_col);
        finish_test("no_similarity", errs_before);
    endtask

    task automatic test_affine_gap();
        int errs_before;
        int exp_score;
        errs_before = err_count;
        exp_score = 8 * int'(sw_pkg::MATCH_SCORE) + int'(sw_pkg::GAP_OPEN) +
                    int'(sw_pkg::GAP_EXTEND);
        // two extra reference bases split the read in the middle
        ref_b  = '{1, 1, 0, 1, 2, 3, 2, 2, 3, 2, 1, 0, 1, 1, 1, 1};
        read_b = '{0, 1, 2, 3, 3, 2, 1, 0};
        run_job(16, 8, 0);
        if (last_score != exp_score) report_mismatch("o_alignment_score", exp_score, last_score);
        if (last_row != 7) report_mismatch("o_row", 7, last_row);
        if (last_col != 11) report_mismatch("o_column", 11, last_col);
        finish_test("affine_gap", errs_before);
    endtask

    task automatic test_ties_short();
        int errs_before;
        errs_before = err_count;
        // row 3 would reach a higher score at column 4 if it were counted
        ref_b  = '{0, 1, 2, 3, 0, 0, 1, 2, 3, 0, 1, 2, 3, 0, 0, 0};
        read_b = '{1, 2, 3, 0, 0, 0, 0, 0};
        run_job(10, 3, 0);
        if (last_score != 3 * int'(sw_pkg::MATCH_SCORE)) begin
            report_mismatch("o_alignment_score", 3 * int'(sw_pkg::MATCH_SCORE), last_score);
        end
        if (last_row != 2) report_mismatch("o_row", 2, last_row);
        if (last_col != 3) report_mismatch("o_column", 3, last_col);
        finish_test("ties_short", errs_before);
    endtask

    task automatic test_backpressure_jobs();
        int errs_before;
        errs_before = err_count;
        fill_random();
        run_job(16, 8, 1 + rand_bits(4));
        for (int n = 0; n < 20; n++) begin
            fill_random();
            run_job(1 + rand_bits(4), 1 + rand_bits(3), 0);
        end
        finish_test("backpressure_jobs", errs_before);
    endtask

    initial begin
        int total_errs;
        rst             = 1'b1;
        i_valid         = 1'b0;
        i_sequence_ref  = '0;
        i_sequence_read = '0;
        i_ref_length    = '0;
        i_read_length   = '0;
        i_ready         = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_exact_match();
        test_no_similarity();
        test_affine_gap();
        test_ties_short();
        test_backpressure_jobs();
        total_errs = err_count + dut.u_assertions.fail_count;
        $display("tests %0d, jobs %0d, errors %0d, assertion failures %0d",
                 test_count, job_count, err_count, dut.u_assertions.fail_count);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* flist.f */
common/sw_pkg.sv
common/sw_pe_link_if.sv
sw_array/sw_pe.sv
sw_array/sw_pe_array.sv
src/sw_controller.sv
src/sw_best_select.sv
src/sw_core.sv
tests/sw_core_assertions.sv
tests/tb_sw_core.sv

/* Bender.yml */
package:
  name: sw_core

sources:
  - files:
      - common/sw_pkg.sv
      - common/sw_pe_link_if.sv
      - sw_array/sw_pe.sv
      - sw_array/sw_pe_array.sv
      - src/sw_controller.sv
      - src/sw_best_select.sv
      - src/sw_core.sv
  - target: test
    files:
      - tests/sw_core_assertions.sv
      - tests/tb_sw_core.sv
